//--- rtl/div_isa_pkg.sv
package div_isa_pkg;

  // ----------------------------------------
  // datapath width
  // ----------------------------------------
  localparam int XLEN = 32;                      // the divide group works on full rv32 words

  typedef logic [XLEN-1:0] xlen_word_t;          // one operand or one result word

  // ----------------------------------------
  // op encoding
  // ----------------------------------------
  // bit 0 low means signed arithmetic and bit 1 high means the remainder is returned
  typedef enum logic [1:0] {
    DIV  = 2'b00,                                // signed quotient
    DIVU = 2'b01,                                // unsigned quotient
    REM  = 2'b10,                                // signed remainder
    REMU = 2'b11                                 // unsigned remainder
  } div_op_e;

  localparam int OP_UNSIGNED_BIT = 0;            // set for DIVU and REMU
  localparam int OP_REM_BIT      = 1;            // set for REM and REMU

  // ----------------------------------------
  // special cases and iteration count
  // ----------------------------------------
  localparam xlen_word_t DIV_ZERO_Q = '1;        // the quotient of a zero divisor is all ones

  // the most negative signed word overflows when divided by minus one
  localparam xlen_word_t INT_MIN = {1'b1, {(XLEN-1){1'b0}}};

  localparam int DIV_STEPS = XLEN;               // one restoring step per quotient bit
  localparam int STEP_W    = $clog2(DIV_STEPS);  // the step counter wraps after the last step

  // counter value while the final step is taken
  localparam logic [STEP_W-1:0] LAST_STEP = STEP_W'(DIV_STEPS - 1);

endpackage

//--- rtl/div_flow_pkg.sv
package div_flow_pkg;

  // ----------------------------------------
  // queue sizing and credits
  // ----------------------------------------
  localparam int QUEUE_DEPTH = 4;                          // entries in the operation queue
  localparam int PTR_W       = $clog2(QUEUE_DEPTH);        // depth is a power of two so pointers wrap
  localparam int CREDIT_W    = $clog2(QUEUE_DEPTH + 1);    // holds every value from zero to full

  // credits held by the issue stage right after reset
  localparam logic [CREDIT_W-1:0] CREDIT_MAX = CREDIT_W'(QUEUE_DEPTH);

  // ----------------------------------------
  // operation record
  // ----------------------------------------
  localparam int TAG_W = 4;                                // tags are opaque to the datapath

  typedef logic [TAG_W-1:0] tag_t;                         // returned unchanged with the result

  // one queued operation is 70 bits wide
  typedef struct packed {
    div_isa_pkg::div_op_e    op;                           // which of the four divide ops
    div_isa_pkg::xlen_word_t dividend;                     // rs1 value
    div_isa_pkg::xlen_word_t divisor;                      // rs2 value
    tag_t                    tag;                          // identifies the request at writeback
  } div_op_t;

endpackage

//--- rtl/div_req_if.sv
interface div_req_if;
  // link between the issue stage and the operation queue
  // the issue stage pushes one operation per pulse of push
  // the queue hands back one credit per pulse of credit_return

  // ----------------------------------------
  // forward path
  // ----------------------------------------
  logic                  push;           // a valid operation sits on op this cycle
  div_flow_pkg::div_op_t op;             // operation being written into the queue

  // ----------------------------------------
  // return path
  // ----------------------------------------
  logic                  credit_return;  // one queue slot was freed this cycle

  // the producer side spends credits and never pushes without one
  modport issue (
    output push,
    output op,
    input  credit_return
  );

  // the consumer side stores the op and reports each released entry
  modport queue (
    input  push,
    input  op,
    output credit_return
  );

endinterface

//--- rtl/divider.sv
module divider (
  input  logic                    CLK,
  input  logic                    nRST,
  input  logic                    start,
  input  logic                    is_signed,
  input  div_isa_pkg::xlen_word_t dividend,
  input  div_isa_pkg::xlen_word_t divisor,
  output logic                    finished,
  output div_isa_pkg::xlen_word_t quotient,
  output div_isa_pkg::xlen_word_t remainder
);

  logic                                busy;      // steps are still being taken
  logic [div_isa_pkg::STEP_W-1:0]      step_cnt;  // steps already done
  logic                                neg_dvd;   // dividend is negative
  logic                                neg_dvs;   // divisor is negative
  logic                                neg_q;     // quotient must be negated at the end
  logic                                neg_r;     // remainder takes the dividend sign
  div_isa_pkg::xlen_word_t             rem_r;     // partial remainder
  div_isa_pkg::xlen_word_t             quo_r;     // dividend bits shift out as quotient bits shift in
  div_isa_pkg::xlen_word_t             dvs_r;     // divisor magnitude
  div_isa_pkg::xlen_word_t             cur_rem;
  div_isa_pkg::xlen_word_t             cur_quo;
  div_isa_pkg::xlen_word_t             cur_dvs;
  logic [div_isa_pkg::XLEN:0]          shifted;   // remainder with the next dividend bit
  logic [div_isa_pkg::XLEN:0]          diff;      // trial subtraction

  // ----------------------------------------
  // one restoring step
  // ----------------------------------------
  assign neg_dvd = is_signed & dividend[div_isa_pkg::XLEN-1];
  assign neg_dvs = is_signed & divisor[div_isa_pkg::XLEN-1];

  // the start cycle already takes the first step on the operand magnitudes
  assign cur_rem = start ? '0 : rem_r;
  assign cur_quo = start ? (neg_dvd ? -dividend : dividend) : quo_r;
  assign cur_dvs = start ? (neg_dvs ? -divisor : divisor) : dvs_r;
  assign shifted = {cur_rem, cur_quo[div_isa_pkg::XLEN-1]};
  assign diff    = shifted - {1'b0, cur_dvs};  // the top bit is set when the divisor did not fit

  // ----------------------------------------
  // step control
  // ----------------------------------------
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      busy     <= 1'b0;
      step_cnt <= '0;
      finished <= 1'b0;
    end else begin
      finished <= busy & (step_cnt == div_isa_pkg::LAST_STEP);  // DIV_STEPS cycles after start
      if (start) begin
        busy     <= 1'b1;
        step_cnt <= 1'b1;
      end else if (busy) begin
        step_cnt <= step_cnt + 1'b1;             // wraps to zero after the final step
        if (step_cnt == div_isa_pkg::LAST_STEP) begin
          busy <= 1'b0;
        end
      end
    end
  end

  // ----------------------------------------
  // datapath registers
  // ----------------------------------------
  always_ff @(posedge CLK) begin
    if (start | busy) begin
      rem_r <= diff[div_isa_pkg::XLEN] ? shifted[div_isa_pkg::XLEN-1:0]
                                       : diff[div_isa_pkg::XLEN-1:0];
      quo_r <= {cur_quo[div_isa_pkg::XLEN-2:0], ~diff[div_isa_pkg::XLEN]};
      dvs_r <= cur_dvs;
    end
    if (start) begin
      neg_q <= neg_dvd ^ neg_dvs;                // signs differ so the quotient is negative
      neg_r <= neg_dvd;
    end
  end

  // sign fix is applied on the way out
  assign quotient  = neg_q ? -quo_r : quo_r;
  assign remainder = neg_r ? -rem_r : rem_r;

endmodule

//--- rtl/divide_unit.sv
module divide_unit (
  input  logic                    CLK,
  input  logic                    nRST,
  input  logic                    q_valid,
  input  div_flow_pkg::div_op_t   q_op,
  output logic                    q_pop,
  output logic                    res_valid,
  output div_isa_pkg::xlen_word_t res_data,
  output div_flow_pkg::tag_t      res_tag
);

  typedef enum logic [1:0] {IDLE, ISSUE, BUSY} du_state_e;

  du_state_e               state;      // sequencer state
  div_flow_pkg::div_op_t   op_r;       // operation being worked on
  logic                    is_signed;  // DIV or REM
  logic                    want_rem;   // REM or REMU
  logic                    div_zero;   // divisor is zero
  logic                    div_ovf;    // signed INT_MIN divided by minus one
  logic                    special;    // result is known without the divider
  logic                    spec_done;  // a special case resolves this cycle
  logic                    div_done;   // the divider completes this cycle
  logic                    start;      // kicks the divider
  logic                    finished;   // divider result is valid
  div_isa_pkg::xlen_word_t quotient;
  div_isa_pkg::xlen_word_t remainder;
  div_isa_pkg::xlen_word_t spec_q;     // quotient of a special case
  div_isa_pkg::xlen_word_t spec_r;     // remainder of a special case

  // ----------------------------------------
  // op decode and special cases
  // ----------------------------------------
  assign q_pop     = (state == IDLE) & q_valid;  // one operation at a time
  assign is_signed = ~op_r.op[div_isa_pkg::OP_UNSIGNED_BIT];
  assign want_rem  = op_r.op[div_isa_pkg::OP_REM_BIT];
  assign div_zero  = (op_r.divisor == '0);
  assign div_ovf   = is_signed & (op_r.dividend == div_isa_pkg::INT_MIN) & (op_r.divisor == '1);
  assign special   = div_zero | div_ovf;         // zero divisor wins when both would apply
  assign spec_q    = div_zero ? div_isa_pkg::DIV_ZERO_Q : div_isa_pkg::INT_MIN;
  assign spec_r    = div_zero ? op_r.dividend : '0;
  assign spec_done = (state == ISSUE) & special;
  assign div_done  = (state == BUSY) & finished;
  assign start     = (state == ISSUE) & ~special; // the cycle after the pop

  divider u_divider (
    .CLK       (CLK),
    .nRST      (nRST),
    .start     (start),
    .is_signed (is_signed),
    .dividend  (op_r.dividend),
    .divisor   (op_r.divisor),
    .finished  (finished),
    .quotient  (quotient),
    .remainder (remainder)
  );

  // ----------------------------------------
  // sequencer
  // ----------------------------------------
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      state     <= IDLE;
      res_valid <= 1'b0;
    end else begin
      res_valid <= spec_done | div_done;         // one pulse per operation
      case (state)
        IDLE:    if (q_valid) state <= ISSUE;
        ISSUE:   state <= special ? IDLE : BUSY;
        BUSY:    if (finished) state <= IDLE;
        default: state <= IDLE;
      endcase
    end
  end

  // operation and result payload registers
  always_ff @(posedge CLK) begin
    if (q_pop) begin
      op_r <= q_op;                              // operands stay stable while the divider runs
    end
    if (spec_done) begin
      res_data <= want_rem ? spec_r : spec_q;
      res_tag  <= op_r.tag;
    end else if (div_done) begin
      res_data <= want_rem ? remainder : quotient;
      res_tag  <= op_r.tag;
    end
  end

endmodule

//--- rtl/div_issue.sv
module div_issue (
  input  logic                    CLK,
  input  logic                    nRST,
  input  logic                    req_valid,
  input  div_isa_pkg::div_op_e    req_op,
  input  div_isa_pkg::xlen_word_t req_rs1,
  input  div_isa_pkg::xlen_word_t req_rs2,
  input  div_flow_pkg::tag_t      req_tag,
  output logic                    req_ready,
  div_req_if.issue                rq
);

  logic [div_flow_pkg::CREDIT_W-1:0] credit_cnt;  // free queue slots known to this stage
  logic                              push_r;      // registered push toward the queue
  div_flow_pkg::div_op_t             op_r;        // registered operation payload
  logic                              accept;      // a request is taken this cycle

  // ----------------------------------------
  // request handshake
  // ----------------------------------------
  assign req_ready = (credit_cnt != '0);          // ready whenever a credit is held
  assign accept    = req_valid & req_ready;       // requests without a credit wait at the port

  // ----------------------------------------
  // credit counter and push flag
  // ----------------------------------------
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      credit_cnt <= div_flow_pkg::CREDIT_MAX;     // the queue starts empty
      push_r     <= 1'b0;
    end else begin
      push_r <= accept;                           // push follows the accept by one cycle
      // a push and a return in the same cycle cancel out
      case ({accept, rq.credit_return})
        2'b10:   credit_cnt <= credit_cnt - 1'b1; // spend one on the accepted request
        2'b01:   credit_cnt <= credit_cnt + 1'b1; // the queue freed a slot
        default: credit_cnt <= credit_cnt;
      endcase
    end
  end

  // ----------------------------------------
  // operation register
  // ----------------------------------------
  always_ff @(posedge CLK) begin
    if (accept) begin
      op_r.op       <= req_op;                    // only loads on an accepted request
      op_r.dividend <= req_rs1;
      op_r.divisor  <= req_rs2;
      op_r.tag      <= req_tag;
    end
  end

  assign rq.push = push_r;                        // the queue writes on this pulse
  assign rq.op   = op_r;                          // payload is stable while push is high

endmodule

//--- rtl/div_op_queue.sv
module div_op_queue (
  input  logic                  CLK,
  input  logic                  nRST,
  div_req_if.queue              rq,
  output logic                  q_valid,
  output div_flow_pkg::div_op_t q_op,
  input  logic                  q_pop
);

  // ----------------------------------------
  // storage and pointers
  // ----------------------------------------
  div_flow_pkg::div_op_t              mem [div_flow_pkg::QUEUE_DEPTH];  // circular buffer
  logic [div_flow_pkg::PTR_W-1:0]     wr_ptr;    // next slot to write
  logic [div_flow_pkg::PTR_W-1:0]     rd_ptr;    // slot of the head entry
  logic [div_flow_pkg::CREDIT_W-1:0]  count;     // entries currently held
  logic                               pop;       // the head leaves this cycle

  assign q_valid = (count != '0);                // head is valid whenever anything is stored
  assign q_op    = mem[rd_ptr];                  // the unit sees the head without delay
  assign pop     = q_pop & q_valid;              // a pop of an empty queue is ignored

  // every released entry frees one slot for the issue stage
  assign rq.credit_return = pop;

  // ----------------------------------------
  // pointer and occupancy update
  // ----------------------------------------
  // the credit protocol keeps pushes away from a full queue
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (rq.push) begin
        wr_ptr <= wr_ptr + 1'b1;                 // wraps at the power of two depth
      end
      if (pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      case ({rq.push, pop})
        2'b10:   count <= count + 1'b1;          // a new entry arrived
        2'b01:   count <= count - 1'b1;          // the head was taken
        default: count <= count;                 // push and pop together keep the level
      endcase
    end
  end

  // ----------------------------------------
  // entry write
  // ----------------------------------------
  always_ff @(posedge CLK) begin
    if (rq.push) begin
      mem[wr_ptr] <= rq.op;                      // visible at q_valid in the next cycle
    end
  end

endmodule

//--- rtl/div_subsystem_top.sv
module div_subsystem_top (
  input  logic                    CLK,
  input  logic                    nRST,
  input  logic                    req_valid,
  input  div_isa_pkg::div_op_e    req_op,
  input  div_isa_pkg::xlen_word_t req_rs1,
  input  div_isa_pkg::xlen_word_t req_rs2,
  input  div_flow_pkg::tag_t      req_tag,
  output logic                    req_ready,
  output logic                    res_valid,
  output div_isa_pkg::xlen_word_t res_data,
  output div_flow_pkg::tag_t      res_tag
);

  // ----------------------------------------
  // internal links
  // ----------------------------------------
  div_req_if             u_req_if ();  // push and credit path between issue and queue
  logic                  q_valid;      // queue holds at least one operation
  div_flow_pkg::div_op_t q_op;         // head of the queue
  logic                  q_pop;        // divide unit takes the head

  // the producer spends credits on incoming requests
  div_issue u_div_issue (
    .CLK       (CLK),
    .nRST      (nRST),
    .req_valid (req_valid),
    .req_op    (req_op),
    .req_rs1   (req_rs1),
    .req_rs2   (req_rs2),
    .req_tag   (req_tag),
    .req_ready (req_ready),
    .rq        (u_req_if.issue)
  );

  // the buffer keeps request order
  div_op_queue u_div_op_queue (
    .CLK     (CLK),
    .nRST    (nRST),
    .rq      (u_req_if.queue),
    .q_valid (q_valid),
    .q_op    (q_op),
    .q_pop   (q_pop)
  );

  // the consumer returns one tagged result per operation
  divide_unit u_divide_unit (
    .CLK       (CLK),
    .nRST      (nRST),
    .q_valid   (q_valid),
    .q_op      (q_op),
    .q_pop     (q_pop),
    .res_valid (res_valid),
    .res_data  (res_data),
    .res_tag   (res_tag)
  );

endmodule

//--- verif/div_sva.sv
module div_sva (
  input logic                              CLK,
  input logic                              nRST,
  input logic [div_flow_pkg::CREDIT_W-1:0] credit_cnt,  // credits held by the issue stage
  input logic                              res_valid    // result strobe of the divide unit
);
  timeunit 1ns;
  timeprecision 1ps;

  // ----------------------------------------
  // credit protocol
  // ----------------------------------------
  // a credit returned by the queue without a matching entry would lift the count too far
  a_credit_bound: assert property (@(posedge CLK) disable iff (!nRST)
    credit_cnt <= div_flow_pkg::CREDIT_MAX)           // never more credits than queue slots
    else $error("credit count above queue depth");

  // ----------------------------------------
  // result strobe
  // ----------------------------------------
  a_single_result: assert property (@(posedge CLK) disable iff (!nRST)
    res_valid |=> !res_valid)                         // the unit needs at least two cycles per op
    else $error("res_valid high in two cycles in a row");

endmodule

// the credit checks sit in the issue stage and the strobe check in the divide unit
bind div_issue div_sva u_issue_sva (
  .CLK        (CLK),
  .nRST       (nRST),
  .credit_cnt (credit_cnt),
  .res_valid  (1'b0)
);

bind divide_unit div_sva u_unit_sva (
  .CLK        (CLK),
  .nRST       (nRST),
  .credit_cnt ('0),
  .res_valid  (res_valid)
);

//--- verif/div_tb.sv
module div_tb;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int NUM_ROWS = 24;                        // twelve corner rows and twelve random rows
  localparam int TIMEOUT  = NUM_ROWS * (div_isa_pkg::DIV_STEPS + 8) + 100;  // in clock cycles

  logic                    CLK;
  logic                    nRST;
  logic                    req_valid;
  div_isa_pkg::div_op_e    req_op;
  div_isa_pkg::xlen_word_t req_rs1;
  div_isa_pkg::xlen_word_t req_rs2;
  div_flow_pkg::tag_t      req_tag;
  logic                    req_ready;
  logic                    res_valid;
  div_isa_pkg::xlen_word_t res_data;
  div_flow_pkg::tag_t      res_tag;

  div_isa_pkg::div_op_e    tbl_op [NUM_ROWS];          // stimulus table
  div_isa_pkg::xlen_word_t tbl_a  [NUM_ROWS];
  div_isa_pkg::xlen_word_t tbl_b  [NUM_ROWS];
  int                      exp_row_q [$];              // accepted rows in request order
  div_isa_pkg::xlen_word_t exp_data_q [$];             // model results for the same rows
  logic [31:0]             rng;                        // xorshift state
  int                      err_cnt;                    // failed compares of any kind
  int                      ok_cnt;                     // tests whose result matched
  int                      bad_cnt;                    // tests with at least one mismatch
  int                      cycle_cnt;
  int                      row;                        // next table row to offer
  int                      gap_left;                   // idle cycles still to insert
  int                      outstanding;                // accepted requests without a result
  int                      done_cnt;

  div_subsystem_top u_div_subsystem_top (
    .CLK       (CLK),
    .nRST      (nRST),
    .req_valid (req_valid),
    .req_op    (req_op),
    .req_rs1   (req_rs1),
    .req_rs2   (req_rs2),
    .req_tag   (req_tag),
    .req_ready (req_ready),
    .res_valid (res_valid),
    .res_data  (res_data),
    .res_tag   (res_tag)
  );

  always #50 CLK = ~CLK;                               // 100 ns period

  // ----------------------------------------
  // reference model and stimulus helpers
  // ----------------------------------------
  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s ^ (s << 13);
    x = x ^ (x >> 17);
    return x ^ (x << 5);
  endfunction

  function automatic div_isa_pkg::xlen_word_t expected_result(input div_isa_pkg::div_op_e op,
      input div_isa_pkg::xlen_word_t a, input div_isa_pkg::xlen_word_t b);
    longint na;
    longint nb;
    longint q;
    longint r;
    logic   sgn;
    logic   rem_sel;
    sgn     = (op == div_isa_pkg::DIV) || (op == div_isa_pkg::REM);
    rem_sel = (op == div_isa_pkg::REM) || (op == div_isa_pkg::REMU);
    if (b == 32'h0) return rem_sel ? a : 32'hffff_ffff;        // zero divisor keeps the dividend
    if (sgn && a == 32'h8000_0000 && b == 32'hffff_ffff) begin
      return rem_sel ? 32'h0 : 32'h8000_0000;                  // overflow wraps back to the minimum
    end
    na = sgn ? longint'($signed(a)) : longint'(a);             // 64 bits hold every operand exactly
    nb = sgn ? longint'($signed(b)) : longint'(b);
    q  = na / nb;                                              // truncates toward zero
    r  = na % nb;                                              // takes the sign of the dividend
    return rem_sel ? r[31:0] : q[31:0];
  endfunction

  task automatic set_row(input int i, input div_isa_pkg::div_op_e op,
                         input div_isa_pkg::xlen_word_t a, input div_isa_pkg::xlen_word_t b);
    tbl_op[i] = op;
    tbl_a[i]  = a;
    tbl_b[i]  = b;
  endtask

  task automatic fill_table();
    set_row(0,  div_isa_pkg::DIV,  32'h0000_0064, 32'h0);        // zero divisor for every op
    set_row(1,  div_isa_pkg::DIVU, 32'hdead_beef, 32'h0);
    set_row(2,  div_isa_pkg::REM,  32'hffff_fff9, 32'h0);
    set_row(3,  div_isa_pkg::REMU, 32'h1234_5678, 32'h0);
    set_row(4,  div_isa_pkg::DIV,  32'h8000_0000, 32'hffff_ffff); // signed overflow
    set_row(5,  div_isa_pkg::REM,  32'h8000_0000, 32'hffff_ffff);
    set_row(6,  div_isa_pkg::DIV,  32'hffff_ff9c, 32'h0000_0007); // negative by positive
    set_row(7,  div_isa_pkg::REM,  32'h0000_0064, 32'hffff_fff9); // positive by negative
    set_row(8,  div_isa_pkg::DIVU, 32'h0000_0005, 32'hffff_fff0); // small by large
    set_row(9,  div_isa_pkg::REMU, 32'h0000_0003, 32'h8000_0001);
    set_row(10, div_isa_pkg::DIVU, 32'hffff_ffff, 32'hffff_ffff); // all ones
    set_row(11, div_isa_pkg::REM,  32'hffff_ffff, 32'h0000_0003);
    for (int i = 12; i < NUM_ROWS; i++) begin
      rng       = xorshift32(rng);
      tbl_op[i] = div_isa_pkg::div_op_e'(rng[1:0]);
      rng       = xorshift32(rng);
      tbl_a[i]  = rng;
      rng       = xorshift32(rng);
      tbl_b[i]  = rng >> rng[4:0];                              // narrow divisors give long quotients
    end
  endtask

  // ----------------------------------------
  // compare tasks
  // ----------------------------------------
  task automatic check_word(input string name, input div_isa_pkg::xlen_word_t got,
                            input div_isa_pkg::xlen_word_t exp);
    if (got !== exp) begin
      $display("ERR %s got %h expected %h", name, got, exp);
      err_cnt++;
    end
  endtask

  task automatic check_tag(input string name, input div_flow_pkg::tag_t got,
                           input div_flow_pkg::tag_t exp);
    if (got !== exp) begin
      $display("ERR %s got %h expected %h", name, got, exp);
      err_cnt++;
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("ERR %s got %h expected %h at cycle %0d", name, got, exp, cycle_cnt);
      err_cnt++;
    end
  endtask

  // ----------------------------------------
  // result collection and request driving
  // ----------------------------------------
  task automatic take_result();
    int                   r;
    int                   errs_before;
    div_isa_pkg::div_op_e op;
    if (exp_row_q.size() == 0) begin
      $display("a result with tag %h arrived while no request was outstanding", res_tag);
      err_cnt++;
    end else begin
      r           = exp_row_q.pop_front();
      op          = tbl_op[r];
      errs_before = err_cnt;
      check_word("res_data", res_data, exp_data_q.pop_front());
      check_tag("res_tag", res_tag, div_flow_pkg::tag_t'(r % 16));  // tags return in request order
      if (err_cnt == errs_before) begin
        ok_cnt++;
      end else begin
        bad_cnt++;
      end
      $display("test %0d %s rs1 %h rs2 %h res %h tag %h %s", r, op.name(), tbl_a[r], tbl_b[r],
               res_data, res_tag, (err_cnt == errs_before) ? "ok" : "mismatch");
      outstanding--;
      done_cnt++;
    end
  endtask

  task automatic step_cycle();
    @(posedge CLK);
    cycle_cnt++;
    // one op in the unit plus a full queue is the only state without credits
    check_bit("req_ready", req_ready, outstanding <= div_flow_pkg::QUEUE_DEPTH);
    if (res_valid) take_result();
    if (req_valid && req_ready) begin                 // the DUT took the row on this edge
      exp_row_q.push_back(row);
      exp_data_q.push_back(expected_result(tbl_op[row], tbl_a[row], tbl_b[row]));
      outstanding++;
      if (row % 8 == 7) gap_left = 3;                 // idle gap after every eighth row
      row++;
    end
    if (gap_left > 0) begin
      req_valid <= 1'b0;
      gap_left--;
    end else if (row < NUM_ROWS) begin
      req_valid <= 1'b1;                              // held until the row is accepted
      req_op    <= tbl_op[row];
      req_rs1   <= tbl_a[row];
      req_rs2   <= tbl_b[row];
      req_tag   <= div_flow_pkg::tag_t'(row % 16);
    end else begin
      req_valid <= 1'b0;
    end
  endtask

  initial begin
    CLK       = 1'b0;
    nRST      = 1'b0;
    req_valid = 1'b0;
    req_op    = div_isa_pkg::DIV;
    req_rs1   = '0;
    req_rs2   = '0;
    req_tag   = '0;
    {err_cnt, ok_cnt, bad_cnt, cycle_cnt, row, gap_left, outstanding, done_cnt} = '0;
    rng = 32'hb0df86c2;
    fill_table();
    repeat (2) @(posedge CLK);
    nRST <= 1'b1;                                     // reset held for two cycles
    @(posedge CLK);
    check_bit("req_ready", req_ready, 1'b1);          // all credits present after reset
    check_bit("res_valid", res_valid, 1'b0);
    while (done_cnt < NUM_ROWS && cycle_cnt < TIMEOUT) step_cycle();
    if (done_cnt < NUM_ROWS) begin
      $display("timeout after %0d cycles, results stopped arriving at %0d of %0d",
               cycle_cnt, done_cnt, NUM_ROWS);
    end else begin
      repeat (div_isa_pkg::DIV_STEPS + 8) step_cycle();  // any extra result shows up here
    end
    $display("results %0d ok %0d mismatched %0d errors %0d", done_cnt, ok_cnt, bad_cnt, err_cnt);
    if (err_cnt == 0 && ok_cnt == NUM_ROWS && done_cnt == NUM_ROWS) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule

//--- list.f
rtl/div_isa_pkg.sv
rtl/div_flow_pkg.sv
rtl/div_req_if.sv
rtl/divider.sv
rtl/divide_unit.sv
rtl/div_issue.sv
rtl/div_op_queue.sv
rtl/div_subsystem_top.sv
verif/div_sva.sv
verif/div_tb.sv

//--- Makefile
SIM      := verilator
FLAGS    := --binary --timing --assert --timescale 1ns/1ps -j 0
TOP      := div_tb
FILELIST := list.f
OBJ_DIR  := obj_dir
BIN      := $(OBJ_DIR)/V$(TOP)
SRCS     := $(filter %.sv,$(shell cat $(FILELIST)))

.PHONY: all run clean

all: $(BIN)

# rebuilt only when a source or the file list changes
$(BIN): $(SRCS) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST) -o V$(TOP)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qx "Regression passed"

clean:
	rm -rf $(OBJ_DIR)
